// File: flist.f
+incdir+rtl
rtl/arcade_pkg.sv
rtl/ps2_key_decoder.sv
rtl/control_mapper.sv
rtl/core_config_regs.sv
rtl/video_blank_expand.sv
rtl/audio_sigma_delta.sv
rtl/arcade_io_top.sv
testbench/tb_arcade_io.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the arcade IO testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	-f flist.f \
	--top-module tb_arcade_io \
	-o tb_arcade_io

./obj_dir/tb_arcade_io > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi

echo "Simulation finished without failure"

// File: testbench/tb_arcade_io.sv
// Arcade IO shell testbench
`timescale 1ns/1ps
`include "arcade_consts.svh"

module tb_arcade_io;

	localparam int TIMEOUT_CYCLES = 4000; // About three times the full run

	logic                     clk_sys;
	logic                     rst;
	logic                     board_button;
	logic [`PS2_KEY_W-1:0]    ps2_key;
	arcade_pkg::joy_t         joy_0;
	arcade_pkg::joy_t         joy_1;
	logic                     wb_cyc;
	logic                     wb_stb;
	logic                     wb_we;
	logic                     wb_ack;
	logic [`WB_ADR_W-1:0]     wb_adr;
	arcade_pkg::wb_data_t     wb_dat_w;
	arcade_pkg::wb_data_t     wb_dat_r;
	arcade_pkg::colour2_t     r;
	arcade_pkg::colour2_t     g;
	arcade_pkg::colour2_t     b;
	logic                     hblank;
	logic                     vblank;
	logic                     hsync;
	logic                     vsync;
	logic                     ce_pix;
	arcade_pkg::audio_t       audio;
	logic                     core_reset;
	logic                     vga_hs;
	logic                     vga_vs;
	logic                     audio_l;
	logic                     audio_r;
	arcade_pkg::player_ctrl_t player;
	arcade_pkg::pixel_t       vga;

	integer seed;
	int     errors = 0;
	int     checks = 0;
	int     test_errors = 0;
	int     tests_run = 0;
	int     cycles = 0;
	logic   line_odd_tb = 1'b0; // Line parity as the testbench sees it
	logic   hs_prev_tb = 1'b0;

	arcade_io_top arcade_io_top_inst (
		.clk_sys(clk_sys), .rst(rst), .board_button(board_button), .ps2_key(ps2_key),
		.joy_0(joy_0), .joy_1(joy_1),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.r(r), .g(g), .b(b), .hblank(hblank), .vblank(vblank),
		.hsync(hsync), .vsync(vsync), .ce_pix(ce_pix), .audio(audio),
		.core_reset(core_reset), .player(player), .vga(vga),
		.vga_hs(vga_hs), .vga_vs(vga_vs), .audio_l(audio_l), .audio_r(audio_r)
	);

	initial clk_sys = 1'b0;
	always #10 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			$display("mismatch at %0d ns: %s = %h, expected %h", $time, name, actual, expected);
			errors++;
			test_errors++;
		end
	endtask

	task automatic report_test(input string name);
		$display("%s test finished with %0d errors", name, test_errors);
		tests_run++;
		test_errors = 0;
	endtask

	// ==============================
	// Bus and keyboard drivers
	// ==============================
	task automatic wb_access(input logic we, input logic [`WB_ADR_W-1:0] adr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int waited;
		rdata = '0;
		@(negedge clk_sys);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdata;
		@(negedge clk_sys);
		waited = 1;
		while (!wb_ack && waited < 8) begin
			@(negedge clk_sys);
			waited++;
		end
		if (!wb_ack) begin
			$display("Wishbone access to address %0d got no ack within 8 cycles", adr);
			errors++;
			test_errors++;
		end else begin
			check_value("ack latency", 32'(waited), 32'd1);
			rdata = wb_dat_r;
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		@(negedge clk_sys);
		check_value("wb_ack", 32'(wb_ack), 32'd0); // Pulse lasts one cycle
	endtask

	task automatic key_event(input arcade_pkg::scancode_t code, input logic pressed);
		@(negedge clk_sys);
		ps2_key = {~ps2_key[`PS2_TOGGLE], pressed, 1'b0, code};
	endtask

	// Scancode for each player struct bit with start2 at bit 0
	function automatic arcade_pkg::scancode_t code_for_bit(input int bit_pos);
		case (bit_pos)
			8:       return `SC_UP;
			7:       return `SC_DOWN;
			6:       return `SC_LEFT;
			5:       return `SC_RIGHT;
			4:       return `SC_FIRE;
			3:       return `SC_BOMB;
			2:       return `SC_COIN;
			1:       return `SC_START1;
			default: return `SC_START2;
		endcase
	endfunction

	// ==============================
	// Tests
	// ==============================
	task automatic keyboard_buttons();
		logic [31:0] rd;
		wb_access(1'b1, `ADDR_CTRL, 32'h1, rd); // Straight directions
		for (int i = 8; i >= 0; i--) begin
			key_event(code_for_bit(i), 1'b1);
			@(negedge clk_sys);
			check_value("player", 32'(player), 32'h1 << i);
			key_event(code_for_bit(i), 1'b0);
			@(negedge clk_sys);
			check_value("player", 32'(player), 32'h0);
		end
		key_event(`SC_FIRE, 1'b1);
		key_event(8'h1C, 1'b1);   // Unmapped key
		key_event(8'h1C, 1'b0);
		@(negedge clk_sys);
		check_value("player", 32'(player), 32'h10);
		key_event(`SC_FIRE, 1'b0);
		@(negedge clk_sys);
	endtask

	task automatic merge_rotation();
		logic [31:0] rd;
		logic m_up;
		logic m_down;
		logic m_left;
		logic m_right;
		arcade_pkg::player_ctrl_t exp_p;
		for (int rot = 0; rot < 2; rot++) begin
			wb_access(1'b1, `ADDR_CTRL, 32'(rot), rd);
			for (int n = 0; n < 16; n++) begin
				joy_0   = 8'($random(seed));
				joy_1   = 8'($random(seed));
				m_up    = joy_0[`JOY_UP] | joy_1[`JOY_UP];
				m_down  = joy_0[`JOY_DOWN] | joy_1[`JOY_DOWN];
				m_left  = joy_0[`JOY_LEFT] | joy_1[`JOY_LEFT];
				m_right = joy_0[`JOY_RIGHT] | joy_1[`JOY_RIGHT];
				exp_p      = '0;
				exp_p.fire = joy_0[`JOY_FIRE] | joy_1[`JOY_FIRE];
				exp_p.bomb = joy_0[`JOY_BOMB] | joy_1[`JOY_BOMB];
				exp_p.up    = rot == 1 ? m_up : m_right;
				exp_p.down  = rot == 1 ? m_down : m_left;
				exp_p.left  = rot == 1 ? m_left : m_up;
				exp_p.right = rot == 1 ? m_right : m_down;
				@(negedge clk_sys);
				check_value("player", 32'(player), 32'(exp_p));
			end
		end
		joy_0 = '0;
		joy_1 = '0;
	endtask

	task automatic register_access();
		logic [31:0] rd;
		wb_access(1'b1, `ADDR_CTRL, 32'hFFFF_FFF5, rd);
		wb_access(1'b0, `ADDR_CTRL, 32'h0, rd);
		check_value("CTRL", rd, 32'h5); // Only bits 3 to 0 are stored
		wb_access(1'b0, `ADDR_ID, 32'h0, rd);
		check_value("ID", rd, `CORE_ID);
		wb_access(1'b1, `ADDR_ID, 32'hA, rd);
		wb_access(1'b0, `ADDR_ID, 32'h0, rd);
		check_value("ID after write", rd, `CORE_ID);
		wb_access(1'b0, `ADDR_CTRL, 32'h0, rd);
		check_value("CTRL after ID write", rd, 32'h5);
		wb_access(1'b0, 2'd3, 32'h0, rd);
		check_value("unknown address", rd, 32'h0);
		key_event(`SC_COIN, 1'b1);
		wb_access(1'b0, `ADDR_BUTTONS, 32'h0, rd);
		check_value("BUTTONS", rd, 32'h4);
		key_event(`SC_COIN, 1'b0);
		wb_access(1'b1, `ADDR_CTRL, 32'h1, rd);
	endtask

	// Expand 2 bits to 6 as c times 21 and darken odd lines
	function automatic arcade_pkg::colour6_t expected_channel(input arcade_pkg::colour2_t c,
		input logic odd, input int lvl);
		int v;
		v = int'(c) * 21;
		if (odd && lvl == 1)
			v = v - v / 4;
		else if (odd && lvl == 2)
			v = v / 2;
		else if (odd && lvl == 3)
			v = v / 4;
		return 6'(v);
	endfunction

	task automatic video_pixels();
		logic [31:0] rd;
		logic hs;
		logic vs;
		logic blank;
		arcade_pkg::pixel_t exp_pix;
		for (int lvl = 0; lvl < 4; lvl++) begin
			wb_access(1'b1, `ADDR_CTRL, {29'd0, 2'(lvl), 1'b1}, rd);
			for (int n = 0; n < 24; n++) begin
				r      = 2'($random(seed));
				g      = 2'($random(seed));
				b      = 2'($random(seed));
				hblank = ($random(seed) & 3) == 0;
				vblank = ($random(seed) & 7) == 0;
				hs     = (n % 6) < 2; // Sync pulse every six pixels
				vs     = 1'($random(seed));
				hsync  = hs;
				vsync  = vs;
				ce_pix = 1'b1;
				blank  = hblank | vblank;
				exp_pix.r = blank ? '0 : expected_channel(r, line_odd_tb, lvl);
				exp_pix.g = blank ? '0 : expected_channel(g, line_odd_tb, lvl);
				exp_pix.b = blank ? '0 : expected_channel(b, line_odd_tb, lvl);
				if (hs && !hs_prev_tb)
					line_odd_tb = ~line_odd_tb;
				hs_prev_tb = hs;
				@(negedge clk_sys);
				check_value("vga", 32'(vga), 32'(exp_pix));
				check_value("vga_hs", 32'(vga_hs), 32'(hs));
				check_value("vga_vs", 32'(vga_vs), 32'(vs));
				ce_pix = 1'b0; // Inputs move while outputs hold
				r      = ~r;
				hsync  = ~hs;
				vsync  = ~vs;
				@(negedge clk_sys);
				check_value("vga held", 32'(vga), 32'(exp_pix));
			end
		end
	endtask

	task automatic run_audio(input arcade_pkg::audio_t sample);
		int ones;
		int ob;
		audio = sample;
		rst   = 1'b1;
		@(negedge clk_sys);
		rst  = 1'b0;
		ones = 0;
		ob   = int'(sample ^ 8'h80); // Offset binary
		repeat (256) begin
			@(negedge clk_sys);
			ones += int'(audio_l);
			check_value("audio_r", 32'(audio_r), 32'(audio_l));
		end
		if (ones + 1 < ob || ones > ob + 1)
			check_value("audio_l ones", 32'(ones), 32'(ob));
	endtask

	task automatic audio_density();
		@(negedge clk_sys);
		run_audio(8'h80);
		run_audio(8'h7F);
		run_audio(8'($random(seed)));
	endtask

	task automatic reset_sources();
		logic [31:0] rd;
		check_value("core_reset", 32'(core_reset), 32'd0);
		wb_access(1'b1, `ADDR_CTRL, 32'h8, rd);
		check_value("core_reset soft", 32'(core_reset), 32'd1);
		wb_access(1'b1, `ADDR_CTRL, 32'h0, rd);
		check_value("core_reset", 32'(core_reset), 32'd0);
		board_button = 1'b1;
		@(negedge clk_sys);
		check_value("core_reset button", 32'(core_reset), 32'd1);
		board_button = 1'b0;
		rst          = 1'b1;
		@(negedge clk_sys);
		check_value("core_reset rst", 32'(core_reset), 32'd1);
		rst = 1'b0;
		@(negedge clk_sys);
		check_value("core_reset", 32'(core_reset), 32'd0);
	endtask

	// ==============================
	// Sequence
	// ==============================
	initial begin
		seed         = 32'hf80545a7;
		rst          = 1'b1;
		board_button = 1'b0;
		ps2_key      = '0;
		joy_0        = '0;
		joy_1        = '0;
		wb_cyc       = 1'b0;
		wb_stb       = 1'b0;
		wb_we        = 1'b0;
		wb_adr       = '0;
		wb_dat_w     = '0;
		r            = '0;
		g            = '0;
		b            = '0;
		hblank       = 1'b0;
		vblank       = 1'b0;
		hsync        = 1'b0;
		vsync        = 1'b0;
		ce_pix       = 1'b0;
		audio        = '0;
		repeat (8) @(negedge clk_sys);
		rst = 1'b0;
		keyboard_buttons();
		report_test("keyboard");
		merge_rotation();
		report_test("merge");
		register_access();
		report_test("registers");
		video_pixels();
		report_test("video");
		audio_density();
		report_test("audio");
		reset_sources();
		report_test("reset");
		$display("%0d tests run, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: rtl/arcade_io_top.sv
// Arcade board IO shell
`timescale 1ns/1ps
`include "arcade_consts.svh"

module arcade_io_top (
	input  logic                     clk_sys,
	input  logic                     rst,
	input  logic                     board_button,
	input  logic [`PS2_KEY_W-1:0]    ps2_key,
	input  arcade_pkg::joy_t         joy_0,
	input  arcade_pkg::joy_t         joy_1,
	// Wishbone host port
	input  logic                     wb_cyc,
	input  logic                     wb_stb,
	input  logic                     wb_we,
	input  logic [`WB_ADR_W-1:0]     wb_adr,
	input  arcade_pkg::wb_data_t     wb_dat_w,
	output arcade_pkg::wb_data_t     wb_dat_r,
	output logic                     wb_ack,
	// Core video and audio
	input  arcade_pkg::colour2_t     r,
	input  arcade_pkg::colour2_t     g,
	input  arcade_pkg::colour2_t     b,
	input  logic                     hblank,
	input  logic                     vblank,
	input  logic                     hsync,
	input  logic                     vsync,
	input  logic                     ce_pix,
	input  arcade_pkg::audio_t       audio,
	// To core and board
	output logic                     core_reset,
	output arcade_pkg::player_ctrl_t player,
	output arcade_pkg::pixel_t       vga,
	output logic                     vga_hs,
	output logic                     vga_vs,
	output logic                     audio_l,
	output logic                     audio_r
);

	arcade_pkg::player_ctrl_t kbd_ctrl;
	arcade_pkg::scan_level_t  scan_level;
	logic                     rotate;
	logic                     soft_reset;

	assign core_reset = rst | soft_reset | board_button;
	assign audio_r    = audio_l; // Mono game

	// ==============================
	// Controls
	// ==============================
	ps2_key_decoder ps2_key_decoder_inst (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.ps2_key  (ps2_key),
		.kbd_ctrl (kbd_ctrl)
	);

	control_mapper control_mapper_inst (
		.kbd_ctrl (kbd_ctrl),
		.joy_0    (joy_0),
		.joy_1    (joy_1),
		.rotate   (rotate),
		.player   (player)
	);

	core_config_regs core_config_regs_inst (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_w   (wb_dat_w),
		.wb_dat_r   (wb_dat_r),
		.wb_ack     (wb_ack),
		.player     (player),
		.rotate     (rotate),
		.scan_level (scan_level),
		.soft_reset (soft_reset)
	);

	// ==============================
	// Video and audio
	// ==============================
	video_blank_expand video_blank_expand_inst (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.ce_pix     (ce_pix),
		.r          (r),
		.g          (g),
		.b          (b),
		.hblank     (hblank),
		.vblank     (vblank),
		.hsync      (hsync),
		.vsync      (vsync),
		.scan_level (scan_level),
		.vga        (vga),
		.vga_hs     (vga_hs),
		.vga_vs     (vga_vs)
	);

	audio_sigma_delta audio_sigma_delta_inst (
		.clk_sys (clk_sys),
		.rst     (rst),
		.audio   (audio),
		.dac_out (audio_l)
	);

endmodule

// File: rtl/audio_sigma_delta.sv
// Sigma-delta audio DAC
`timescale 1ns/1ps
`include "arcade_consts.svh"

module audio_sigma_delta (
	input  logic               clk_sys,
	input  logic               rst,
	input  arcade_pkg::audio_t audio,
	output logic               dac_out
);

	logic [`ACC_W-1:0] sample_ob; // Offset binary, scaled up
	logic [`ACC_W-1:0] acc;
	logic [`ACC_W:0]   sum;       // Extra bit is the carry

	// Flip the sign bit for offset binary, pad with zeros below
	assign sample_ob = {~audio[`AUDIO_W-1], audio[`AUDIO_W-2:0], {(`ACC_W-`AUDIO_W){1'b0}}};
	assign sum       = {1'b0, acc} + {1'b0, sample_ob};

	// ==============================
	// First-order modulator
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			acc     <= '0;
			dac_out <= 1'b0;
		end else begin
			acc     <= sum[`ACC_W-1:0];
			dac_out <= sum[`ACC_W]; // Carry density tracks the sample
		end
	end

endmodule

// File: rtl/video_blank_expand.sv
// VGA colour expand and scanlines
`timescale 1ns/1ps

module video_blank_expand (
	input  logic                    clk_sys,
	input  logic                    rst,
	input  logic                    ce_pix,
	input  arcade_pkg::colour2_t    r,
	input  arcade_pkg::colour2_t    g,
	input  arcade_pkg::colour2_t    b,
	input  logic                    hblank,
	input  logic                    vblank,
	input  logic                    hsync,
	input  logic                    vsync,
	input  arcade_pkg::scan_level_t scan_level,
	output arcade_pkg::pixel_t      vga,
	output logic                    vga_hs,
	output logic                    vga_vs
);

	logic               hs_prev;  // Sync as of the last pixel enable
	logic               line_odd;
	logic               blank;
	arcade_pkg::pixel_t pix_next;

	// Expand one channel, then darken it on odd lines
	function automatic arcade_pkg::colour6_t shade(input arcade_pkg::colour2_t c,
		input logic odd, input arcade_pkg::scan_level_t lvl);
		arcade_pkg::colour6_t v;
		v = {c, c, c};
		if (odd) begin
			case (lvl)
				2'd1:    v = v - (v >> 2); // 25%
				2'd2:    v = v >> 1;       // 50%
				2'd3:    v = v >> 2;       // 75%
				default: ;
			endcase
		end
		return v;
	endfunction

	assign blank = hblank | vblank;

	always_comb begin
		pix_next.r = blank ? '0 : shade(r, line_odd, scan_level);
		pix_next.g = blank ? '0 : shade(g, line_odd, scan_level);
		pix_next.b = blank ? '0 : shade(b, line_odd, scan_level);
	end

	// ==============================
	// Pixel and line parity
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			hs_prev  <= 1'b0;
			line_odd <= 1'b0;
			vga      <= '0;
			vga_hs   <= 1'b0;
			vga_vs   <= 1'b0;
		end else if (ce_pix) begin
			hs_prev <= hsync;
			if (hsync && !hs_prev)
				line_odd <= ~line_odd; // New line starts on rising hsync
			vga    <= pix_next;
			vga_hs <= hsync;
			vga_vs <= vsync;
		end
	end

endmodule

// File: rtl/core_config_regs.sv
// Wishbone configuration registers
`timescale 1ns/1ps
`include "arcade_consts.svh"

module core_config_regs (
	input  logic                     clk_sys,
	input  logic                     rst,
	input  logic                     wb_cyc,
	input  logic                     wb_stb,
	input  logic                     wb_we,
	input  logic [`WB_ADR_W-1:0]     wb_adr,
	input  arcade_pkg::wb_data_t     wb_dat_w,
	output arcade_pkg::wb_data_t     wb_dat_r,
	output logic                     wb_ack,
	input  arcade_pkg::player_ctrl_t player,
	output logic                     rotate,
	output arcade_pkg::scan_level_t  scan_level,
	output logic                     soft_reset
);

	logic                 access;    // Request seen, not yet acked
	logic                 ctrl_wr;
	arcade_pkg::wb_data_t ctrl_word; // CTRL as read back

	assign access  = wb_cyc & wb_stb & ~wb_ack;
	assign ctrl_wr = access & wb_we & (wb_adr == arcade_pkg::REG_CTRL);

	// ==============================
	// Bus handshake
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= access; // Single cycle pulse
		end
	end

	// CTRL register
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			rotate     <= 1'b0;
			scan_level <= '0;
			soft_reset <= 1'b0;
		end else if (ctrl_wr) begin
			rotate     <= wb_dat_w[`CTRL_ROTATE];
			scan_level <= wb_dat_w[`CTRL_SCAN_HI:`CTRL_SCAN_LO];
			soft_reset <= wb_dat_w[`CTRL_SOFT_RESET];
		end
	end

	// ==============================
	// Read mux
	// ==============================
	always_comb begin
		ctrl_word = '0;
		ctrl_word[`CTRL_ROTATE]                  = rotate;
		ctrl_word[`CTRL_SCAN_HI:`CTRL_SCAN_LO]   = scan_level;
		ctrl_word[`CTRL_SOFT_RESET]              = soft_reset;
	end

	// Address is held until ack, so the data is steady while ack is high
	always_comb begin
		case (wb_adr)
			arcade_pkg::REG_CTRL:    wb_dat_r = ctrl_word;
			arcade_pkg::REG_BUTTONS: wb_dat_r = arcade_pkg::wb_data_t'(player); // Live state
			arcade_pkg::REG_ID:      wb_dat_r = `CORE_ID;
			default:                 wb_dat_r = '0;
		endcase
	end

endmodule

// File: rtl/control_mapper.sv
// Player control merge and rotation
`timescale 1ns/1ps
`include "arcade_consts.svh"

module control_mapper (
	input  arcade_pkg::player_ctrl_t kbd_ctrl,
	input  arcade_pkg::joy_t         joy_0,
	input  arcade_pkg::joy_t         joy_1,
	input  logic                     rotate,
	output arcade_pkg::player_ctrl_t player
);

	logic m_up;
	logic m_down;
	logic m_left;
	logic m_right;

	// ==============================
	// Merge keyboard and joysticks
	// ==============================
	assign m_up    = kbd_ctrl.up    | joy_0[`JOY_UP]    | joy_1[`JOY_UP];
	assign m_down  = kbd_ctrl.down  | joy_0[`JOY_DOWN]  | joy_1[`JOY_DOWN];
	assign m_left  = kbd_ctrl.left  | joy_0[`JOY_LEFT]  | joy_1[`JOY_LEFT];
	assign m_right = kbd_ctrl.right | joy_0[`JOY_RIGHT] | joy_1[`JOY_RIGHT];

	always_comb begin
		player.fire   = kbd_ctrl.fire | joy_0[`JOY_FIRE] | joy_1[`JOY_FIRE];
		player.bomb   = kbd_ctrl.bomb | joy_0[`JOY_BOMB] | joy_1[`JOY_BOMB];
		player.coin   = kbd_ctrl.coin;   // Keyboard only
		player.start1 = kbd_ctrl.start1;
		player.start2 = kbd_ctrl.start2;

		// Cabinet is mounted sideways, so the default turns the stick 90 degrees
		if (rotate) begin
			player.up    = m_up;
			player.down  = m_down;
			player.left  = m_left;
			player.right = m_right;
		end else begin
			player.up    = m_right;
			player.down  = m_left;
			player.left  = m_up;
			player.right = m_down;
		end
	end

endmodule

// File: rtl/ps2_key_decoder.sv
// Keyboard button decoder
`timescale 1ns/1ps
`include "arcade_consts.svh"

module ps2_key_decoder (
	input  logic                      clk_sys,
	input  logic                      rst,
	input  logic [`PS2_KEY_W-1:0]     ps2_key,
	output arcade_pkg::player_ctrl_t  kbd_ctrl
);

	logic                  toggle_prev; // Last seen event toggle
	logic                  new_event;
	logic                  pressed;
	arcade_pkg::scancode_t code;

	assign new_event = ps2_key[`PS2_TOGGLE] != toggle_prev;
	assign pressed   = ps2_key[`PS2_PRESSED];
	assign code      = ps2_key[`SCANCODE_W-1:0];

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			toggle_prev <= 1'b0;
		end else begin
			toggle_prev <= ps2_key[`PS2_TOGGLE];
		end
	end

	// Button latches, one per mapped key
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			kbd_ctrl <= '0;
		end else if (new_event) begin
			case (code)
				`SC_UP:     kbd_ctrl.up     <= pressed;
				`SC_DOWN:   kbd_ctrl.down   <= pressed;
				`SC_LEFT:   kbd_ctrl.left   <= pressed;
				`SC_RIGHT:  kbd_ctrl.right  <= pressed;
				`SC_FIRE:   kbd_ctrl.fire   <= pressed;
				`SC_BOMB:   kbd_ctrl.bomb   <= pressed;
				`SC_COIN:   kbd_ctrl.coin   <= pressed;
				`SC_START1: kbd_ctrl.start1 <= pressed;
				`SC_START2: kbd_ctrl.start2 <= pressed;
				default:    ; // Unmapped key, nothing to do
			endcase
		end
	end

endmodule

// File: rtl/arcade_pkg.sv
// Arcade IO shared types
`include "arcade_consts.svh"

package arcade_pkg;

	// ==============================
	// Vector types
	// ==============================
	typedef logic [`COLOUR2_W-1:0]    colour2_t;    // Core colour channel
	typedef logic [`COLOUR6_W-1:0]    colour6_t;    // VGA colour channel
	typedef logic [`SCANCODE_W-1:0]   scancode_t;
	typedef logic [`JOY_W-1:0]        joy_t;        // R L D U fire bomb
	typedef logic [`AUDIO_W-1:0]      audio_t;      // Two's complement
	typedef logic [`WB_DATA_W-1:0]    wb_data_t;
	typedef logic [`SCAN_LEVEL_W-1:0] scan_level_t; // 0 off, 1..3 darker

	// ==============================
	// Structs
	// ==============================

	// Player controls, up is the MSB
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
		logic bomb;
		logic coin;
		logic start1;
		logic start2;
	} player_ctrl_t;

	typedef struct packed {
		colour6_t r;
		colour6_t g;
		colour6_t b;
	} pixel_t;

	// Register block addresses
	typedef enum logic [`WB_ADR_W-1:0] {
		REG_CTRL    = `ADDR_CTRL,
		REG_BUTTONS = `ADDR_BUTTONS,
		REG_ID      = `ADDR_ID
	} reg_addr_e;

endpackage

// File: rtl/arcade_consts.svh
// Arcade IO shared constants
`ifndef ARCADE_CONSTS_SVH
`define ARCADE_CONSTS_SVH

// ==============================
// Widths
// ==============================
`define COLOUR2_W      2
`define COLOUR6_W      6
`define SCANCODE_W     8
`define JOY_W          8
`define AUDIO_W        8
`define WB_DATA_W      32
`define WB_ADR_W       2
`define SCAN_LEVEL_W   2
`define PS2_KEY_W      11
`define ACC_W          16

// Keyboard event word fields
`define PS2_TOGGLE     10
`define PS2_PRESSED    9

// Joystick word bit positions
`define JOY_RIGHT      0
`define JOY_LEFT       1
`define JOY_DOWN       2
`define JOY_UP         3
`define JOY_FIRE       4
`define JOY_BOMB       5

// ==============================
// Scancodes
// ==============================
`define SC_UP          8'h75
`define SC_DOWN        8'h72
`define SC_LEFT        8'h6B
`define SC_RIGHT       8'h74
`define SC_COIN        8'h76 // Esc
`define SC_START1      8'h05 // F1
`define SC_START2      8'h06 // F2
`define SC_FIRE        8'h29 // Space
`define SC_BOMB        8'h11 // Alt

// ==============================
// Register map
// ==============================
`define ADDR_CTRL      2'd0
`define ADDR_BUTTONS   2'd1
`define ADDR_ID        2'd2
`define CORE_ID        32'h444F524F

// CTRL bit positions
`define CTRL_ROTATE     0
`define CTRL_SCAN_LO    1
`define CTRL_SCAN_HI    2
`define CTRL_SOFT_RESET 3

`endif
